// ==== div_unit.sv ====
module div_unit import muldiv_pkg::*; (
	input logic clk,
	input logic rst_n,
	muldiv_if.unit bus
);

	logic busy;
	div_cnt_t cnt;
	logic done_q;
	data_t result_q;

	data_t quo;	// Dividend shifts out while quotient bits shift in
	data_t rem_q;
	data_t dsr;
	logic neg_q;
	logic neg_r;
	logic is_rem;

	logic start_rem;
	logic signed_op;
	logic div_zero;
	logic overflow;
	data_t mag_a;
	data_t mag_b;
	data_t special;

	logic [xlen:0] r_sh;
	logic [xlen:0] diff;
	logic fits;
	data_t r_next;
	data_t q_next;
	data_t fixed_q;
	data_t fixed_r;
	logic last_step;

	always_comb begin
		start_rem = (bus.op == REM) || (bus.op == REMU);
		signed_op = (bus.op == DIV) || (bus.op == REM);
		div_zero = (bus.raw_b == '0);
		overflow = signed_op && (bus.raw_a == {1'b1, {(xlen-1){1'b0}}}) && (bus.raw_b == '1);
		mag_a = bus.a[xlen] ? -bus.raw_a : bus.raw_a;
		mag_b = bus.b[xlen] ? -bus.raw_b : bus.raw_b;
		if (div_zero)
			special = start_rem ? bus.raw_a : '1;
		else
			special = start_rem ? '0 : {1'b1, {(xlen-1){1'b0}}};
	end

	// One restoring step, the borrow out of diff says whether the divisor fits
	always_comb begin
		r_sh = {rem_q, quo[xlen-1]};
		diff = r_sh - {1'b0, dsr};
		fits = !diff[xlen];
		r_next = fits ? diff[xlen-1:0] : r_sh[xlen-1:0];
		q_next = {quo[xlen-2:0], fits};
		fixed_q = neg_q ? -q_next : q_next;
		fixed_r = neg_r ? -r_next : r_next;
		last_step = busy && (cnt == div_cnt_t'(div_cycles-1));
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (bus.start) begin
				cnt <= '0;
				if (div_zero || overflow)
					done_q <= 1'b1;	// Answered without iterating
				else
					busy <= 1'b1;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (last_step) begin
					busy <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus.start) begin
			quo <= mag_a;
			rem_q <= '0;
			dsr <= mag_b;
			neg_q <= bus.a[xlen] ^ bus.b[xlen];
			neg_r <= bus.a[xlen];	// Remainder follows the dividend
			is_rem <= start_rem;
			result_q <= special;
		end else if (busy) begin
			quo <= q_next;
			rem_q <= r_next;
			if (last_step)
				result_q <= is_rem ? fixed_r : fixed_q;
		end
	end

	assign bus.done = done_q;
	assign bus.result = result_q;

endmodule

// ==== files.f ====
muldiv_pkg.sv
muldiv_if.sv
muldiv_issue.sv
mul_unit.sv
div_unit.sv
muldiv_retire.sv
muldiv_top.sv
muldiv_chk.sv
tb_muldiv.sv

// ==== mul_unit.sv ====
module mul_unit import muldiv_pkg::*; (
	input logic clk,
	input logic rst_n,
	muldiv_if.unit bus
);

	logic signed [2*xlen+1:0] prod;
	funct3_t op1;
	logic v1;
	logic done_q;
	data_t result_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			done_q <= 1'b0;
		end else begin
			v1 <= bus.start;
			done_q <= v1;
		end
	end

	// Both operands carry their own sign bit, so one signed multiply covers all four forms
	always_ff @(posedge clk) begin
		if (bus.start) begin
			prod <= bus.a * bus.b;
			op1 <= bus.op;
		end
	end

	always_ff @(posedge clk) begin
		if (v1) begin
			if (op1 == MUL)
				result_q <= prod[xlen-1:0];
			else
				result_q <= prod[2*xlen-1:xlen];	// MULH, MULHSU and MULHU
		end
	end

	assign bus.done = done_q;
	assign bus.result = result_q;

endmodule

// ==== muldiv_chk.sv ====
module muldiv_chk import muldiv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input funct3_t req_op,
	input data_t req_a,
	input data_t req_b,
	input logic credit_return,
	input logic res_valid,
	input data_t res_data,
	input logic out_credit
);
	timeunit 1ns;
	timeprecision 100ps;

	data_t exp_q [$];
	int grants;	// Output slots granted and not yet used
	int up_credits;	// Mirror of the upstream credit count
	int err_cnt;
	logic head_ok;

	// Reference from the RV32M rules, kept apart from the DUT datapath
	function automatic data_t expect_result(funct3_t op, data_t a, data_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0] ua;
		logic [63:0] ub;
		logic [63:0] p;
		logic signed [31:0] qa;
		logic signed [31:0] qb;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		ua = {32'h0, a};
		ub = {32'h0, b};
		qa = a;
		qb = b;
		case (op)
			MUL: p = sa * sb;
			MULH: p = sa * sb;
			MULHSU: p = sa * ub;
			MULHU: p = ua * ub;
			default: p = '0;
		endcase
		case (op)
			MUL: return p[31:0];
			MULH, MULHSU, MULHU: return p[63:32];
			DIV: begin
				if (b == 0)
					return 32'hffff_ffff;
				if (a == 32'h8000_0000 && b == 32'hffff_ffff)
					return 32'h8000_0000;	// Signed overflow
				return qa / qb;
			end
			DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
			REM: begin
				if (b == 0)
					return a;
				if (a == 32'h8000_0000 && b == 32'hffff_ffff)
					return 32'h0;
				return qa % qb;
			end
			default: return (b == 0) ? a : a % b;
		endcase
	endfunction

	initial err_cnt = 0;

	always @(posedge clk) begin
		if (!rst_n) begin
			exp_q.delete();
			grants <= 0;
			up_credits <= result_depth;
		end else begin
			if (res_valid && exp_q.size() != 0)
				void'(exp_q.pop_front());
			if (req_valid)
				exp_q.push_back(expect_result(req_op, req_a, req_b));
			grants <= grants + int'(out_credit) - int'(res_valid);
			up_credits <= up_credits - int'(req_valid) + int'(credit_return);
		end
	end

	always_comb head_ok = (exp_q.size() != 0) && (res_data == exp_q[0]);

	a_result: assert property (@(posedge clk) disable iff (!rst_n) res_valid |-> head_ok)
		else begin
			err_cnt = err_cnt + 1;
			$error("result mismatch or unexpected result");
		end

	a_grant: assert property (@(posedge clk) disable iff (!rst_n) res_valid |-> grants > 0)
		else begin
			err_cnt = err_cnt + 1;
			$error("result sent without an output credit");
		end

	a_up_range: assert property (@(posedge clk) disable iff (!rst_n)
		up_credits >= 0 && up_credits <= result_depth)
		else begin
			err_cnt = err_cnt + 1;
			$error("upstream credit count out of range");
		end

	a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !res_valid && !credit_return)
		else begin
			err_cnt = err_cnt + 1;
			$error("outputs active right after reset");
		end

endmodule

// ==== muldiv_if.sv ====
interface muldiv_if import muldiv_pkg::*; ();

	logic start;	// One-cycle pulse
	funct3_t op;
	opnd_t a;
	opnd_t b;
	data_t raw_a;
	data_t raw_b;
	logic done;	// One-cycle pulse
	data_t result;

	// Issue also watches done to know when the unit is free again
	modport issue (
		output start, op, a, b, raw_a, raw_b,
		input done
	);

	modport unit (
		input start, op, a, b, raw_a, raw_b,
		output done, result
	);

	modport monitor (
		input done, result
	);

endinterface

// ==== muldiv_issue.sv ====
module muldiv_issue import muldiv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input funct3_t req_op,
	input data_t req_a,
	input data_t req_b,
	muldiv_if.issue mul_bus,
	muldiv_if.issue div_bus
);

	// Requests that could not start at once wait here in order
	funct3_t hold_op [result_depth];
	data_t hold_a [result_depth];
	data_t hold_b [result_depth];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	credit_t hold_cnt;

	logic [mul_latency-1:0] mul_pipe;
	logic div_busy;
	logic mul_start;
	logic div_start;

	logic hold_empty;
	logic pend_valid;
	funct3_t pend_op;
	data_t pend_a;
	data_t pend_b;
	logic pend_mul;
	logic a_sgn;
	logic b_sgn;
	logic mul_busy;
	logic div_free;
	logic issue;
	logic push;
	logic pop;

	funct3_t op_q;
	opnd_t a_q;
	opnd_t b_q;
	data_t raw_a_q;
	data_t raw_b_q;

	// Oldest waiting request goes first, a new one bypasses an empty hold
	assign hold_empty = (hold_cnt == '0);
	assign pend_valid = req_valid || !hold_empty;
	assign pend_op = hold_empty ? req_op : hold_op[rd_ptr];
	assign pend_a = hold_empty ? req_a : hold_a[rd_ptr];
	assign pend_b = hold_empty ? req_b : hold_b[rd_ptr];
	assign pend_mul = is_mul_op(pend_op);

	assign a_sgn = pend_op inside {MUL, MULH, MULHSU, DIV, REM};
	assign b_sgn = pend_op inside {MUL, MULH, DIV, REM};

	assign mul_busy = mul_start || (|mul_pipe);
	assign div_free = !div_busy || div_bus.done;	// Next start may follow done directly
	// Divides wait for the multiplier to drain so completions keep request order
	assign issue = pend_valid && div_free && (pend_mul || !mul_busy);

	assign push = req_valid && !(hold_empty && issue);
	assign pop = issue && !hold_empty;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			hold_cnt <= '0;
			mul_pipe <= '0;
			div_busy <= 1'b0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			hold_cnt <= hold_cnt + credit_t'(push) - credit_t'(pop);
			mul_pipe <= {mul_pipe[mul_latency-2:0], mul_start};
			mul_start <= issue && pend_mul;
			div_start <= issue && !pend_mul;
			if (issue && !pend_mul)
				div_busy <= 1'b1;
			else if (div_bus.done)
				div_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			hold_op[wr_ptr] <= req_op;
			hold_a[wr_ptr] <= req_a;
			hold_b[wr_ptr] <= req_b;
		end
		if (issue) begin
			op_q <= pend_op;
			a_q <= {a_sgn & pend_a[xlen-1], pend_a};	// Sign or zero extend to 33 bits
			b_q <= {b_sgn & pend_b[xlen-1], pend_b};
			raw_a_q <= pend_a;
			raw_b_q <= pend_b;
		end
	end

	assign mul_bus.start = mul_start;
	assign mul_bus.op = op_q;
	assign mul_bus.a = a_q;
	assign mul_bus.b = b_q;
	assign mul_bus.raw_a = raw_a_q;
	assign mul_bus.raw_b = raw_b_q;

	assign div_bus.start = div_start;
	assign div_bus.op = op_q;
	assign div_bus.a = a_q;
	assign div_bus.b = b_q;
	assign div_bus.raw_a = raw_a_q;
	assign div_bus.raw_b = raw_b_q;

endmodule

// ==== muldiv_pkg.sv ====
package muldiv_pkg;

	localparam int xlen = 32;
	localparam int result_depth = 4;	// Result queue entries and input credits
	localparam int div_cycles = 32;	// One quotient bit per cycle
	localparam int mul_latency = 2;

	localparam int ptr_w = $clog2(result_depth);
	localparam int div_cnt_w = $clog2(div_cycles);
	// Downstream may grant several slots ahead of results
	localparam int out_credit_w = 8;

	typedef enum logic [2:0] {
		MUL    = 3'd0,
		MULH   = 3'd1,
		MULHSU = 3'd2,
		MULHU  = 3'd3,
		DIV    = 3'd4,
		DIVU   = 3'd5,
		REM    = 3'd6,
		REMU   = 3'd7
	} funct3_t;

	typedef logic [xlen-1:0] data_t;

	// Operand with one extra bit so signed and unsigned forms share one datapath
	typedef logic signed [xlen:0] opnd_t;

	typedef logic [$clog2(result_depth+1)-1:0] credit_t;
	typedef logic [ptr_w-1:0] ptr_t;
	typedef logic [div_cnt_w-1:0] div_cnt_t;
	typedef logic [out_credit_w-1:0] out_credit_t;

	// The four multiplies have funct3[2] clear
	function automatic logic is_mul_op(funct3_t op);
		return !op[2];
	endfunction

endpackage

// ==== muldiv_retire.sv ====
module muldiv_retire import muldiv_pkg::*; (
	input logic clk,
	input logic rst_n,
	muldiv_if.monitor mul_bus,
	muldiv_if.monitor div_bus,
	input logic out_credit,
	output logic res_valid,
	output data_t res_data,
	output logic credit_return
);

	data_t mem [result_depth];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	credit_t count;
	out_credit_t out_cnt;	// Slots granted by downstream and not yet used

	logic push;
	data_t push_data;

	// Issue ordering keeps the two done pulses apart
	assign push = mul_bus.done || div_bus.done;
	assign push_data = mul_bus.done ? mul_bus.result : div_bus.result;

	assign res_valid = (count != '0) && (out_cnt != '0);
	assign res_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_cnt <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (res_valid)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + credit_t'(push) - credit_t'(res_valid);
			out_cnt <= out_cnt + out_credit_t'(out_credit) - out_credit_t'(res_valid);
			credit_return <= res_valid;	// Frees one upstream slot per result sent
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

endmodule

// ==== muldiv_top.sv ====
module muldiv_top import muldiv_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input funct3_t req_op,
	input data_t req_a,
	input data_t req_b,
	output logic credit_return,
	output logic res_valid,
	output data_t res_data,
	input logic out_credit
);

	muldiv_if mul_bus ();
	muldiv_if div_bus ();

	muldiv_issue u_issue (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_op    (req_op),
		.req_a     (req_a),
		.req_b     (req_b),
		.mul_bus   (mul_bus),
		.div_bus   (div_bus)
	);

	mul_unit u_mul (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (mul_bus)
	);

	div_unit u_div (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (div_bus)
	);

	muldiv_retire u_retire (
		.clk           (clk),
		.rst_n         (rst_n),
		.mul_bus       (mul_bus),
		.div_bus       (div_bus),
		.out_credit    (out_credit),
		.res_valid     (res_valid),
		.res_data      (res_data),
		.credit_return (credit_return)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_muldiv -f files.f -o sim_muldiv \
	&& ./obj_dir/sim_muldiv +verilator+error+limit+100 \
	|| exit 1

// ==== tb_muldiv.sv ====
module tb_muldiv import muldiv_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_requests = 400;
	localparam int cycle_limit = n_requests * (div_cycles + 4) + 2000;	// Slack for the stall

	logic clk;
	logic rst_n;
	logic req_valid;
	funct3_t req_op;
	data_t req_a;
	data_t req_b;
	logic credit_return;
	logic res_valid;
	data_t res_data;
	logic out_credit;

	int credits;
	int sent;
	int received;
	int cycles;
	int slots;	// Output slots granted and not yet used by the DUT
	logic stall;
	data_t corners [5];

	muldiv_top dut (.*);

	bind muldiv_top muldiv_chk chk (.*);

	task automatic report_failure(string msg);
		$display("FAILED %0t %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// Caller sits 2 ns after a rising edge
	task automatic send_req(funct3_t op, data_t a, data_t b);
		while (credits == 0) begin
			req_valid = 1'b0;
			@(posedge clk);
			#2;
		end
		req_valid = 1'b1;
		req_op = op;
		req_a = a;
		req_b = b;
		credits--;
		sent++;
		@(posedge clk);
		#2;
		req_valid = 1'b0;
	endtask

	function automatic data_t pick_operand();
		if ($urandom % 4 == 0)
			return corners[$urandom % 5];
		return $urandom;
	endfunction

	task automatic wait_drained();
		while (received != sent || credits != result_depth) begin
			@(posedge clk);
			#2;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst_n) begin
			if (credit_return)
				credits++;
			if (res_valid)
				received++;
			if (out_credit)
				slots++;
			if (res_valid)
				slots--;
		end
		cycles++;
		if (cycles >= cycle_limit)
			report_failure("timeout, results did not all come back");
		if (dut.chk.err_cnt != 0)
			report_failure("checker assertion failed");
	end

	// Downstream grants slots in random bursts unless stalled, like a buffer of its own
	initial begin
		out_credit = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			out_credit = rst_n && !stall && (slots < result_depth) && ($urandom % 3 != 0);
		end
	end

	initial begin
		void'($urandom(32'hc5d9_a551));
		corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_op = MUL;
		req_a = '0;
		req_b = '0;
		stall = 1'b0;
		credits = result_depth;
		sent = 0;
		received = 0;
		cycles = 0;
		slots = 0;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// Every op on every pair of corner values
		for (int op = 0; op < 8; op++)
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++)
					send_req(funct3_t'(op), corners[i], corners[j]);

		for (int k = 0; k < 100; k++)
			send_req(funct3_t'($urandom % 8), pick_operand(), pick_operand());

		// Downstream stall, only four requests may get through
		wait_drained();
		stall = 1'b1;
		@(posedge clk);
		#2;
		while (slots != 0) begin	// Spend slots granted before the stall one result at a time
			send_req(funct3_t'($urandom % 8), pick_operand(), pick_operand());
			wait_drained();
		end
		repeat (4)
			send_req(funct3_t'($urandom % 8), pick_operand(), pick_operand());
		repeat (200) begin
			@(posedge clk);
			#2;
			if (credits != 0)
				report_failure("credit came back while downstream was stalled");
		end
		stall = 1'b0;

		for (int k = 0; k < 80; k++)
			send_req(funct3_t'($urandom % 8), pick_operand(), pick_operand());

		wait_drained();
		repeat (4) @(posedge clk);
		if (dut.chk.err_cnt == 0 && received == sent) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			report_failure("results missing or checker errors at end of run");
		end
	end

endmodule
